// File: hw/free_list.sv
`include "rename_defs.svh"

module free_list (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  alloc_i,
    input  rename_pkg::commit_t   commit_i,
    output rename_pkg::phys_reg_t head_o,
    output logic                  empty_o
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(`RN_FREE_DEPTH);

    phys_reg_t        entries_q [`RN_FREE_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    // Register 0 is hardwired and never goes back on the list
    assign push = commit_i.valid && (commit_i.old_prd != '0);
    assign pop  = alloc_i && !empty_o;

    assign head_o  = entries_q[head_q];
    assign empty_o = (count_q == '0);

    //////////////////////////////////////////////////
    // Circular buffer
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            // Starts full with the registers above the identity map
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                entries_q[i] <= phys_reg_t'(`RN_NUM_ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (PTR_W+1)'(`RN_FREE_DEPTH);
        end else begin
            if (push) begin
                entries_q[tail_q] <= commit_i.old_prd;
                tail_q            <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            // Push and pop together leave the level unchanged
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: hw/operand_read.sv
module operand_read (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  rename_pkg::renamed_t renamed_i,
    input  rename_pkg::wb_port_t wb1_i,
    input  rename_pkg::wb_port_t wb2_i,
    output rename_pkg::issue_t   issue_o
);
    import rename_pkg::*;

    logic     rr_valid_q;
    renamed_t rr_q;
    data_t    rf_data1;
    data_t    rf_data2;
    logic     hit1_wb1;
    logic     hit1_wb2;
    logic     hit2_wb1;
    logic     hit2_wb2;
    issue_t   issue_d;
    logic     issue_valid_q;
    issue_t   issue_q;

    //////////////////////////////////////////////////
    // Rename to read register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rr_valid_q <= 1'b0;
        end else begin
            rr_valid_q <= renamed_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        rr_q <= renamed_i;
    end

    phys_regfile regfile_i (
        .clk_i    (clk_i),
        .wb1_i    (wb1_i),
        .wb2_i    (wb2_i),
        .raddr1_i (rr_q.prs1),
        .raddr2_i (rr_q.prs2),
        .rdata1_o (rf_data1),
        .rdata2_o (rf_data2)
    );

    //////////////////////////////////////////////////
    // Snoop and bypass
    //////////////////////////////////////////////////

    // Writebacks now are not in the register file yet
    assign hit1_wb1 = wb_hit(wb1_i, rr_q.prs1);
    assign hit1_wb2 = wb_hit(wb2_i, rr_q.prs1);
    assign hit2_wb1 = wb_hit(wb1_i, rr_q.prs2);
    assign hit2_wb2 = wb_hit(wb2_i, rr_q.prs2);

    always_comb begin
        issue_d.valid      = rr_valid_q;
        issue_d.rs1        = rr_q.rs1;
        issue_d.rs2        = rr_q.rs2;
        issue_d.rd         = rr_q.rd;
        issue_d.regfile_we = rr_q.regfile_we;
        issue_d.prs1       = rr_q.prs1;
        issue_d.rdy1       = rr_q.rdy1 | hit1_wb1 | hit1_wb2;
        issue_d.prs2       = rr_q.prs2;
        issue_d.rdy2       = rr_q.rdy2 | hit2_wb1 | hit2_wb2;
        issue_d.prd        = rr_q.prd;
        issue_d.old_prd    = rr_q.old_prd;
        issue_d.data_rs1   = hit1_wb1 ? wb1_i.data : (hit1_wb2 ? wb2_i.data : rf_data1);
        issue_d.data_rs2   = hit2_wb1 ? wb1_i.data : (hit2_wb2 ? wb2_i.data : rf_data2);
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= issue_d.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        issue_q <= issue_d;
    end

    always_comb begin
        issue_o       = issue_q;
        issue_o.valid = issue_valid_q;
    end

endmodule

// File: hw/phys_regfile.sv
`include "rename_defs.svh"

module phys_regfile (
    input  logic                  clk_i,
    input  rename_pkg::wb_port_t  wb1_i,
    input  rename_pkg::wb_port_t  wb2_i,
    input  rename_pkg::phys_reg_t raddr1_i,
    input  rename_pkg::phys_reg_t raddr2_i,
    output rename_pkg::data_t     rdata1_o,
    output rename_pkg::data_t     rdata2_o
);
    import rename_pkg::*;

    data_t regs_q [`RN_NUM_PHYS_REGS];

    //////////////////////////////////////////////////
    // Write ports
    //////////////////////////////////////////////////

    // Ports never target the same register in one cycle
    always_ff @(posedge clk_i) begin
        if (wb1_i.valid && (wb1_i.prd != '0)) begin
            regs_q[wb1_i.prd] <= wb1_i.data;
        end
        if (wb2_i.valid && (wb2_i.prd != '0)) begin
            regs_q[wb2_i.prd] <= wb2_i.data;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Register 0 is the zero register
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

// File: hw/rename_core.sv
module rename_core (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  rename_pkg::rename_req_t rename_i,
    input  rename_pkg::wb_port_t    wb1_i,
    input  rename_pkg::wb_port_t    wb2_i,
    input  rename_pkg::commit_t     commit_i,
    output logic                    rename_ready_o,
    output rename_pkg::issue_t      issue_o
);
    import rename_pkg::*;

    logic      free_empty;
    logic      accept;
    logic      alloc;
    phys_reg_t head_prd;
    renamed_t  renamed;

    // Ready while a destination can still be handed out
    assign rename_ready_o = !free_empty;
    assign accept         = rename_i.valid && rename_ready_o;

    //////////////////////////////////////////////////
    // Rename
    //////////////////////////////////////////////////

    free_list free_list_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .alloc_i  (alloc),
        .commit_i (commit_i),
        .head_o   (head_prd),
        .empty_o  (free_empty)
    );

    rename_table rename_table_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .rename_i  (rename_i),
        .accept_i  (accept),
        .new_prd_i (head_prd),
        .wb1_i     (wb1_i),
        .wb2_i     (wb2_i),
        .alloc_o   (alloc),
        .renamed_o (renamed)
    );

    //////////////////////////////////////////////////
    // Operand read
    //////////////////////////////////////////////////

    operand_read operand_read_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .renamed_i (renamed),
        .wb1_i     (wb1_i),
        .wb2_i     (wb2_i),
        .issue_o   (issue_o)
    );

endmodule

// File: hw/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

//////////////////////////////////////////////////
// Register counts
//////////////////////////////////////////////////

`define RN_NUM_ARCH_REGS 32
`define RN_NUM_PHYS_REGS 64

// Registers left over after the identity map
`define RN_FREE_DEPTH (`RN_NUM_PHYS_REGS - `RN_NUM_ARCH_REGS)

//////////////////////////////////////////////////
// Index and data widths
//////////////////////////////////////////////////

`define RN_ARCH_IDX_W 5
`define RN_PHYS_IDX_W 6
`define RN_DATA_W     64

`endif

// File: hw/rename_pkg.sv
`include "rename_defs.svh"

package rename_pkg;

    typedef logic [`RN_ARCH_IDX_W-1:0] arch_reg_t;
    typedef logic [`RN_PHYS_IDX_W-1:0] phys_reg_t;
    typedef logic [`RN_DATA_W-1:0]     data_t;

    // Incoming request from decode
    typedef struct packed {
        logic      valid;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      regfile_we;
    } rename_req_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t prd;
        data_t     data;
    } wb_port_t;

    // Frees the previous mapping of a retired destination
    typedef struct packed {
        logic      valid;
        phys_reg_t old_prd;
    } commit_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      regfile_we;
        phys_reg_t prs1;
        logic      rdy1;
        phys_reg_t prs2;
        logic      rdy2;
        phys_reg_t prd;
        phys_reg_t old_prd;
    } renamed_t;

    // Renamed instruction with its operands
    typedef struct packed {
        logic      valid;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      regfile_we;
        phys_reg_t prs1;
        logic      rdy1;
        phys_reg_t prs2;
        logic      rdy2;
        phys_reg_t prd;
        phys_reg_t old_prd;
        data_t     data_rs1;
        data_t     data_rs2;
    } issue_t;

    // Writeback snoop, physical register 0 never matches
    function automatic logic wb_hit(wb_port_t wb, phys_reg_t prs);
        return wb.valid && (wb.prd == prs) && (prs != '0);
    endfunction

endpackage

// File: hw/rename_table.sv
`include "rename_defs.svh"

module rename_table (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  rename_pkg::rename_req_t rename_i,
    input  logic                    accept_i,
    input  rename_pkg::phys_reg_t   new_prd_i,
    input  rename_pkg::wb_port_t    wb1_i,
    input  rename_pkg::wb_port_t    wb2_i,
    output logic                    alloc_o,
    output rename_pkg::renamed_t    renamed_o
);
    import rename_pkg::*;

    phys_reg_t                    map_q [`RN_NUM_ARCH_REGS];
    logic [`RN_NUM_PHYS_REGS-1:0] ready_q;
    phys_reg_t                    prs1;
    phys_reg_t                    prs2;

    // Only real destinations take a register
    assign alloc_o = accept_i && rename_i.regfile_we && (rename_i.rd != '0);

    assign prs1 = map_q[rename_i.rs1];
    assign prs2 = map_q[rename_i.rs2];

    //////////////////////////////////////////////////
    // Map lookup and ready snoop
    //////////////////////////////////////////////////

    always_comb begin
        renamed_o.valid      = accept_i;
        renamed_o.rs1        = rename_i.rs1;
        renamed_o.rs2        = rename_i.rs2;
        renamed_o.rd         = rename_i.rd;
        renamed_o.regfile_we = rename_i.regfile_we;
        renamed_o.prs1       = prs1;
        renamed_o.prs2       = prs2;
        // Writebacks in this cycle count as ready already
        renamed_o.rdy1       = ready_q[prs1] | wb_hit(wb1_i, prs1) | wb_hit(wb2_i, prs1);
        renamed_o.rdy2       = ready_q[prs2] | wb_hit(wb1_i, prs2) | wb_hit(wb2_i, prs2);
        renamed_o.prd        = alloc_o ? new_prd_i : '0;
        renamed_o.old_prd    = alloc_o ? map_q[rename_i.rd] : '0;
    end

    //////////////////////////////////////////////////
    // Map and ready update
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `RN_NUM_ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
            ready_q <= '1;
        end else begin
            if (wb1_i.valid) begin
                ready_q[wb1_i.prd] <= 1'b1;
            end
            if (wb2_i.valid) begin
                ready_q[wb2_i.prd] <= 1'b1;
            end
            // New destination waits for its own writeback
            if (alloc_o) begin
                map_q[rename_i.rd] <= new_prd_i;
                ready_q[new_prd_i] <= 1'b0;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module rename_core_tb -f verilog.f -Mdir obj_dir -o rename_core_sim

./obj_dir/rename_core_sim 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: tb/rename_core_sva.sv
module rename_core_sva (
    input logic                    clk_i,
    input logic                    rstn_i,
    input rename_pkg::rename_req_t rename_i,
    input rename_pkg::wb_port_t    wb1_i,
    input rename_pkg::wb_port_t    wb2_i,
    input logic                    rename_ready_o,
    input rename_pkg::issue_t      issue_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import rename_pkg::*;

    logic accept;

    assign accept = rename_i.valid && rename_ready_o;

    // Driver holds off while the free list is empty
    no_req_when_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(rename_i.valid && !rename_ready_o))
        else $error("request raised while rename_ready_o is low");

    issue_after_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept |-> ##2 issue_o.valid)
        else $error("accepted request did not issue two cycles later");

    issue_from_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_o.valid |-> $past(accept, 2))
        else $error("issue_o.valid without a request two cycles before");

    dest_gets_reg: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (accept && rename_i.regfile_we && (rename_i.rd != '0)) |-> ##2 (issue_o.prd != '0))
        else $error("destination issued with physical register 0");

    no_wb_to_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(wb1_i.valid && (wb1_i.prd == '0)) && !(wb2_i.valid && (wb2_i.prd == '0)))
        else $error("writeback to physical register 0");

endmodule

bind rename_core rename_core_sva rename_core_sva_i (.*);

// File: tb/rename_core_tb.sv
`include "rename_defs.svh"

module rename_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rename_pkg::*;

    logic        clk_i;
    logic        rstn_i;
    rename_req_t rename_i;
    wb_port_t    wb1_i;
    wb_port_t    wb2_i;
    commit_t     commit_i;
    logic        rename_ready_o;
    issue_t      issue_o;

    // Model state
    phys_reg_t model_map [`RN_NUM_ARCH_REGS];
    logic      model_ready [`RN_NUM_PHYS_REGS];
    data_t     model_data [`RN_NUM_PHYS_REGS];
    phys_reg_t free_q [$];
    phys_reg_t commit_pool [$];
    issue_t    expect_q [$];
    issue_t    stage_item;
    logic      stage_valid;
    int        seed;

    rename_core rename_core_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic snoop(wb_port_t wb, phys_reg_t p);
        return wb.valid && (wb.prd == p) && (p != '0);
    endfunction

    // Rename stage view in the accept cycle
    function automatic issue_t predict_rename(rename_req_t req, wb_port_t w1, wb_port_t w2);
        issue_t it;
        logic   alloc;
        alloc         = req.regfile_we && (req.rd != '0);
        it            = '0;
        it.valid      = 1'b1;
        it.rs1        = req.rs1;
        it.rs2        = req.rs2;
        it.rd         = req.rd;
        it.regfile_we = req.regfile_we;
        it.prs1       = model_map[req.rs1];
        it.prs2       = model_map[req.rs2];
        it.rdy1       = model_ready[it.prs1] | snoop(w1, it.prs1) | snoop(w2, it.prs1);
        it.rdy2       = model_ready[it.prs2] | snoop(w1, it.prs2) | snoop(w2, it.prs2);
        it.prd        = alloc ? free_q[0] : '0;
        it.old_prd    = alloc ? model_map[req.rd] : '0;
        return it;
    endfunction

    // Operand read one cycle later, newest data wins
    function automatic issue_t complete_operands(issue_t it, wb_port_t w1, wb_port_t w2);
        it.rdy1     = it.rdy1 | snoop(w1, it.prs1) | snoop(w2, it.prs1);
        it.rdy2     = it.rdy2 | snoop(w1, it.prs2) | snoop(w2, it.prs2);
        it.data_rs1 = snoop(w1, it.prs1) ? w1.data :
                      (snoop(w2, it.prs1) ? w2.data : model_data[it.prs1]);
        it.data_rs2 = snoop(w1, it.prs2) ? w1.data :
                      (snoop(w2, it.prs2) ? w2.data : model_data[it.prs2]);
        return it;
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < `RN_NUM_ARCH_REGS; i++) begin
            model_map[i] = phys_reg_t'(i);
        end
        for (int i = 0; i < `RN_NUM_PHYS_REGS; i++) begin
            model_ready[i] = 1'b1;
            model_data[i]  = '0;
        end
        for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
            free_q.push_back(phys_reg_t'(`RN_NUM_ARCH_REGS + i));
        end
        stage_valid = 1'b0;
    endfunction

    function automatic void update_model();
        if (wb1_i.valid && (wb1_i.prd != '0)) begin
            model_ready[wb1_i.prd] = 1'b1;
            model_data[wb1_i.prd]  = wb1_i.data;
        end
        if (wb2_i.valid && (wb2_i.prd != '0)) begin
            model_ready[wb2_i.prd] = 1'b1;
            model_data[wb2_i.prd]  = wb2_i.data;
        end
        if (stage_valid && (stage_item.prd != '0)) begin
            model_map[stage_item.rd]     = stage_item.prd;
            model_ready[stage_item.prd] = 1'b0;
            free_q.delete(0);
        end
        if (commit_i.valid && (commit_i.old_prd != '0)) begin
            free_q.push_back(commit_i.old_prd);
        end
    endfunction

    // Free registers left for the cycle after this one
    function automatic int free_next();
        int n;
        n = free_q.size();
        if (rename_i.valid && rename_ready_o && rename_i.regfile_we && (rename_i.rd != '0)) begin
            n--;
        end
        if (commit_i.valid && (commit_i.old_prd != '0)) begin
            n++;
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic check_field(string name, logic [63:0] got, logic [63:0] expv);
        if (got !== expv) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expv);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_error(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic compare_issue(issue_t e);
        check_field("issue_o.rs1", issue_o.rs1, e.rs1);
        check_field("issue_o.rs2", issue_o.rs2, e.rs2);
        check_field("issue_o.rd", issue_o.rd, e.rd);
        check_field("issue_o.regfile_we", issue_o.regfile_we, e.regfile_we);
        check_field("issue_o.prs1", issue_o.prs1, e.prs1);
        check_field("issue_o.prs2", issue_o.prs2, e.prs2);
        check_field("issue_o.rdy1", issue_o.rdy1, e.rdy1);
        check_field("issue_o.rdy2", issue_o.rdy2, e.rdy2);
        check_field("issue_o.prd", issue_o.prd, e.prd);
        check_field("issue_o.old_prd", issue_o.old_prd, e.old_prd);
        // Data only means something once ready
        if (e.rdy1) begin
            check_field("issue_o.data_rs1", issue_o.data_rs1, e.data_rs1);
        end
        if (e.rdy2) begin
            check_field("issue_o.data_rs2", issue_o.data_rs2, e.data_rs2);
        end
    endtask

    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (issue_o.valid) begin
                if (expect_q.size() == 0) begin
                    report_error("issue_o.valid is high with no accepted request");
                end else begin
                    compare_issue(expect_q[0]);
                    if (expect_q[0].old_prd != '0) begin
                        commit_pool.push_back(expect_q[0].old_prd);
                    end
                    expect_q.delete(0);
                end
            end
            if (stage_valid) begin
                expect_q.push_back(complete_operands(stage_item, wb1_i, wb2_i));
            end
            stage_valid = rename_i.valid && rename_ready_o;
            if (stage_valid) begin
                stage_item = predict_rename(rename_i, wb1_i, wb2_i);
            end
            update_model();
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic step(rename_req_t req, wb_port_t w1, wb_port_t w2, commit_t c);
        @(posedge clk_i);
        rename_i <= req;
        wb1_i    <= w1;
        wb2_i    <= w2;
        commit_i <= c;
    endtask

    function automatic wb_port_t make_wb(phys_reg_t p, data_t d);
        return {1'b1, p, d};
    endfunction

    task automatic issue_rename(arch_reg_t rs1, arch_reg_t rs2, arch_reg_t rd, logic we,
                                wb_port_t w1, wb_port_t w2);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (free_next() == 0) begin
            waited++;
            if (waited > 50) begin
                report_error("timed out waiting for a free register");
            end
            step('0, '0, '0, '0);
            @(negedge clk_i);
        end
        step({1'b1, rs1, rs2, rd, we}, w1, w2, '0);
    endtask

    task automatic random_cycle();
        rename_req_t req;
        wb_port_t    w1;
        wb_port_t    w2;
        commit_t     c;
        int          p1;
        @(negedge clk_i);
        req       = rename_req_t'($random(seed));
        req.valid = (($random(seed) & 3) != 0) && (free_next() > 0);
        p1        = 1 + ($unsigned($random(seed)) % 63);
        w1        = make_wb(phys_reg_t'(p1), {$random(seed), $random(seed)});
        w1.valid  = 1'($random(seed));
        // Second port never hits the first port's register
        w2        = make_wb(phys_reg_t'(1 + (p1 + ($unsigned($random(seed)) % 62)) % 63),
                            {$random(seed), $random(seed)});
        w2.valid  = 1'($random(seed));
        c         = '0;
        if ((commit_pool.size() != 0) && $random(seed)) begin
            c = {1'b1, commit_pool.pop_front()};
        end
        step(req, w1, w2, c);
    endtask

    initial begin
        int  waited;
        logic full;
        seed        = 32'h73f;
        rstn_i      = 1'b0;
        rename_i    = '0;
        wb1_i       = '0;
        wb2_i       = '0;
        commit_i    = '0;
        reset_model();
        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;

        // Clear the register file, two registers a cycle
        for (int p = 1; p < `RN_NUM_PHYS_REGS; p += 2) begin
            step('0, make_wb(phys_reg_t'(p), '0),
                 (p + 1 < `RN_NUM_PHYS_REGS) ? make_wb(phys_reg_t'(p + 1), '0) : '0, '0);
        end
        // Identity map
        for (int i = 0; i < 8; i++) begin
            issue_rename(arch_reg_t'(i), arch_reg_t'(31 - i), '0, 1'b0, '0, '0);
        end
        // Arch 1 to 4 take 32 to 35
        for (int i = 1; i <= 4; i++) begin
            issue_rename(arch_reg_t'(i), arch_reg_t'(i), arch_reg_t'(i), 1'b1, '0, '0);
        end
        issue_rename(5'd1, 5'd2, '0, 1'b0, '0, '0);
        // Writeback before, during and after renaming
        step('0, make_wb(6'd32, 64'h1111_2222_3333_4444), '0, '0);
        issue_rename(5'd1, 5'd2, '0, 1'b0, make_wb(6'd33, 64'h5555_6666_7777_8888), '0);
        issue_rename(5'd3, 5'd4, '0, 1'b0, '0, '0);
        step('0, make_wb(6'd34, 64'h9999_aaaa_bbbb_cccc),
             make_wb(6'd35, 64'hdddd_eeee_ffff_0001), '0);

        // Drain the free list
        full = 1'b0;
        for (int n = 0; (n < 60) && !full; n++) begin
            @(negedge clk_i);
            if (free_next() == 0) begin
                full = 1'b1;
            end else begin
                step({1'b1, 5'd7, 5'd8, arch_reg_t'(1 + n % 31), 1'b1}, '0, '0, '0);
            end
        end
        if (!full) begin
            report_error("free list never ran empty");
        end
        step('0, '0, '0, '0);
        @(negedge clk_i);
        check_field("rename_ready_o", rename_ready_o, 64'd0);
        waited = 0;
        while (commit_pool.size() < 2) begin
            waited++;
            if (waited > 20) begin
                report_error("timed out waiting for committable registers");
            end
            step('0, '0, '0, '0);
            @(negedge clk_i);
        end
        step('0, '0, '0, {1'b1, commit_pool.pop_front()});
        step('0, '0, '0, {1'b1, commit_pool.pop_front()});
        step('0, '0, '0, '0);
        issue_rename(5'd9, 5'd10, 5'd11, 1'b1, '0, '0);
        issue_rename(5'd11, 5'd12, 5'd12, 1'b1, '0, '0);

        repeat (400) random_cycle();
        step('0, '0, '0, '0);

        waited = 0;
        while ((expect_q.size() != 0) || stage_valid) begin
            waited++;
            if (waited > 20) begin
                report_error("timed out waiting for issue_o to drain");
            end
            @(posedge clk_i);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/rename_pkg.sv
hw/free_list.sv
hw/rename_table.sv
hw/phys_regfile.sv
hw/operand_read.sv
hw/rename_core.sv
tb/rename_core_sva.sv
tb/rename_core_tb.sv
